/* dv/cpuTb.sv */
`default_nettype none

module cpuTb import cpuPkg::*;;

	localparam int InDelay = 10;
	localparam int MaxWords = 256;
	// Condition field 0xF never passes
	localparam word_t NopWord = 48'hF00000000000;
	// ASCII codes seen by the file reader
	localparam int EofChar = -1;
	localparam int NewLine = 10;
	localparam int CommentChar = 35;
	localparam int ProgChar = 80;
	localparam int StoreChar = 83;

	typedef struct packed {
		logic [127:0] name;
		word_t addr;
		word_t data;
	} storeRec_t;

	logic clk;
	logic reset;
	word_t instr;
	word_t pcF;
	logic memWrite;
	word_t aluOut;
	word_t writeData;

	word_t prog [MaxWords];
	int progLen = 0;
	storeRec_t expQ [$];
	storeRec_t rec;
	logic loaded = 1'b0;
	logic startChecked = 1'b0;
	int checked = 0;
	int mismatches = 0;
	int extraStores = 0;
	int missingStores = 0;
	int fileErrors = 0;

	cpuTop #(
		.DataWords(64)
	) DUT (
		.clk(clk),
		.reset(reset),
		.instr(instr),
		.pcF(pcF),
		.memWrite(memWrite),
		.aluOut(aluOut),
		.writeData(writeData)
	);

	// Instruction ROM with a NOP past the end of the program
	function automatic word_t fetchWord(input word_t addr);
		if (addr[1:0] != 2'b00 || (addr >> 2) >= word_t'(progLen)) begin
			return NopWord;
		end
		return prog[addr[9:2]];
	endfunction

	task automatic checkValue(input logic [127:0] name, input logic [31:0] field,
			input word_t expected, input word_t actual);
		if (expected !== actual) begin
			mismatches++;
			$display("MISMATCH %0s %0s: expected %h, actual %h", name, field, expected, actual);
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ROM answers for the PC set at the last edge
	initial begin
		instr = NopWord;
		forever begin
			@(posedge clk);
			#InDelay;
			instr = fetchWord(pcF);
		end
	end

	// Stores are compared in program order
	always @(negedge clk) begin
		if (!reset && !startChecked) begin
			checkValue(128'("resetPc"), "pc  ", '0, pcF);
			startChecked = 1'b1;
		end
		if (!reset && memWrite === 1'b1) begin
			if (expQ.size() == 0) begin
				extraStores++;
				$display("Store with no expected record left: address %h, data %h",
					aluOut, writeData);
			end else begin
				rec = expQ.pop_front();
				checkValue(rec.name, "addr", rec.addr, aluOut);
				checkValue(rec.name, "data", rec.data, writeData);
				checked++;
			end
		end
	end

	initial begin
		wait (loaded);
		repeat ((progLen + 20) * 4) @(posedge clk);
		$display("Timeout: the program did not reach its end in time");
		$display("Done: errors found");
		$finish;
	end

	initial begin
		int fd;
		int c;
		int code;
		word_t word;
		logic [127:0] name;
		word_t addr;
		word_t data;
		storeRec_t left;
		reset = 1'b1;
		fd = $fopen("dv/programInput.txt", "r");
		if (fd == 0) begin
			fileErrors++;
			$display("Could not open dv/programInput.txt");
		end else begin
			c = $fgetc(fd);
			while (c != EofChar) begin
				if (c == CommentChar) begin
					while (c != NewLine && c != EofChar) begin
						c = $fgetc(fd);
					end
				end else if (c == ProgChar) begin
					code = $fscanf(fd, "%h", word);
					if (code != 1 || progLen >= MaxWords) begin
						fileErrors++;
						$display("Bad or surplus program line in the input file");
					end else begin
						prog[progLen] = word;
						progLen++;
					end
				end else if (c == StoreChar) begin
					code = $fscanf(fd, "%s %h %h", name, addr, data);
					if (code != 3) begin
						fileErrors++;
						$display("Bad store record in the input file");
					end else begin
						expQ.push_back('{name: name, addr: addr, data: data});
					end
				end
				if (c != EofChar) begin
					c = $fgetc(fd);
				end
			end
			$fclose(fd);
		end
		loaded = 1'b1;

		repeat (3) @(posedge clk);
		#InDelay;
		reset = 1'b0;

		// Program is done once fetch is well past its last word
		while (pcF < word_t'((progLen + 8) * 4)) begin
			@(negedge clk);
		end
		repeat (2) @(negedge clk);

		missingStores = expQ.size();
		while (expQ.size() > 0) begin
			left = expQ.pop_front();
			$display("Expected store %0s never happened", left.name);
		end
		$display("Stores checked %0d, mismatches %0d, unexpected stores %0d, %s %0d, %s %0d",
			checked, mismatches, extraStores, "missing stores", missingStores,
			"file errors", fileErrors);
		if (mismatches == 0 && extraStores == 0 && missingStores == 0 && fileErrors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* dv/programInput.txt */
# P <instruction word, hex>                    program word, in address order from 0
# S <test name> <byte address, hex> <data, hex>  expected store, in the order they occur
P E1D002123456  # MOV r1, #0x123456
P E1D00400F0F0  # MOV r2, #0xF0F0
P E1D014000040  # MOV r10, #0x40  store base
P E04046000002  # ADD r3, r1, r2
P E020C800000A  # SUB r4, r3, r10
P E0010A000001  # AND r5, r4, r1
P E0C14C000002  # ORR r6, r5, r2
P E0D00E000006  # MOV r7, r6
P E3028E000000  # STR r7, [r10, #0x00]
P E30286000004  # STR r3, [r10, #0x04]
P E30288000008  # STR r4, [r10, #0x08]
P E3028A00000C  # STR r5, [r10, #0x0C]
P E3028C000010  # STR r6, [r10, #0x10]
P E14050FFFFF0  # ADD r8, r1, #-16
P E1D012FFFFFF  # MOV r9, #-1
P E30292000018  # STR r9, [r10, #0x18]
P E14252000003  # ADD r9, r9, #3  wraps to 2
P E30290000014  # STR r8, [r10, #0x14]
P E3029200001C  # STR r9, [r10, #0x1C]
P E3028C000020  # STR r6, [r10, #0x20]
P E31296000020  # LDR r11, [r10, #0x20]
P E142D8000001  # ADD r12, r11, #1  load-use
P E30298000024  # STR r12, [r10, #0x24]
P E1D01A000005  # MOV r13, #5
P E12B5C000005  # SUBS r14, r13, #5  Z=1 C=1
P 03029A000028  # STREQ r13, [r10, #0x28]
P 13029A00002C  # STRNE r13, [r10, #0x2C]  skipped
P 114B5E000001  # ADDSNE r15, r13, #1  skipped, flags kept
P 03029C000030  # STREQ r14, [r10, #0x30]
P A3029A000034  # STRGE r13, [r10, #0x34]
P B3029A000038  # STRLT r13, [r10, #0x38]  skipped
P E12B9C000001  # SUBS r14, r14, #1  N=1
P B3029C00003C  # STRLT r14, [r10, #0x3C]
P A3029C000040  # STRGE r14, [r10, #0x40]  skipped
P 13029A000044  # STRNE r13, [r10, #0x44]
P 140000000002  # BNE +2  taken, target 0x98
P E3029A000048  # STR r13, [r10, #0x48]  flushed
P E3029A00004C  # STR r13, [r10, #0x4C]  flushed
P E3029C000050  # STR r14, [r10, #0x50]
P 040000000002  # BEQ +2  not taken
P E30298000054  # STR r12, [r10, #0x54]
P E30282000058  # STR r1, [r10, #0x58]
S aluMov 40 12F4F6
S aluAdd 44 132546
S aluSub 48 132506
S aluAnd 4C 122406
S aluOrr 50 12F4F6
S movNegImm 58 FFFFFFFFFFFF
S addNegImm 54 123446
S immWrap 5C 000000000002
S storeLoad 60 12F4F6
S loadUse 64 12F4F7
S condEq 68 000000000005
S condFlagsKept 70 000000000000
S condGe 74 000000000005
S condLt 7C FFFFFFFFFFFF
S condNe 84 000000000005
S branchTarget 90 FFFFFFFFFFFF
S branchNotTaken 94 12F4F7
S afterBranch 98 123456

/* list.f */
verilog/cpuPkg.sv
verilog/decoder.sv
verilog/condLogic.sv
verilog/alu.sv
verilog/regFile.sv
verilog/hazardUnit.sv
verilog/cpu.sv
verilog/dataMem.sv
verilog/cpuTop.sv
dv/cpuTb.sv

/* run.sh */
#!/bin/sh
# Builds the CPU testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module cpuTb -o cpuSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/cpuSim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qxF "Done: no errors"; then
	exit 0
fi
exit 1

/* verilog/alu.sv */
`default_nettype none

module alu import cpuPkg::*; (
	input word_t a,
	input word_t b,
	input aluOp_t aluOp,
	output word_t result,
	output flags_t flags
);

	logic isSub;
	word_t bIn;
	logic [48:0] sum;
	logic carry;
	logic overflow;

	// Subtract as a plus inverted b plus one
	assign isSub = (aluOp == SUB);
	assign bIn = isSub ? ~b : b;
	assign sum = {1'b0, a} + {1'b0, bIn} + {48'd0, isSub};

	always_comb begin
		carry = 1'b0;
		overflow = 1'b0;
		case (aluOp)
			ADD, SUB: begin
				result = sum[47:0];
				carry = sum[48];
				// Same operand signs, different result sign
				overflow = (a[47] == bIn[47]) && (sum[47] != a[47]);
			end
			AND: result = a & b;
			ORR: result = a | b;
			MOV: result = b;
			default: result = '0;
		endcase
	end

	assign flags = {result[47], result == '0, carry, overflow};

endmodule

`default_nettype wire

/* verilog/condLogic.sv */
`default_nettype none

module condLogic import cpuPkg::*; (
	input logic clk,
	input logic reset,
	input cond_t cond,
	input flags_t aluFlags,
	input logic flagWrite,
	output logic condEx
);

	flags_t flags;
	logic n;
	logic z;
	logic v;

	assign n = flags[3];
	assign z = flags[2];
	assign v = flags[0];

	// Condition checked against the stored flags
	always_comb begin
		case (condCode_t'(cond))
			EQ: condEx = z;
			NE: condEx = !z;
			GE: condEx = (n == v);
			LT: condEx = (n != v);
			GT: condEx = !z && (n == v);
			LE: condEx = z || (n != v);
			AL: condEx = 1'b1;
			default: condEx = 1'b0;
		endcase
	end

	// A failing instruction leaves the flags alone
	always_ff @(posedge clk) begin
		if (reset) begin
			flags <= '0;
		end else if (flagWrite && condEx) begin
			flags <= aluFlags;
		end
	end

endmodule

`default_nettype wire

/* verilog/cpu.sv */
`default_nettype none

module cpu import cpuPkg::*; (
	input logic clk,
	input logic reset,
	input word_t instr,
	input word_t readData,
	output word_t pcF,
	output word_t aluOut,
	output word_t writeData,
	output logic memWrite
);

	// Fetch/decode register
	word_t instrD;
	word_t pcD;
	logic validD;

	// Decode
	opcode_t opD;
	decodeCtrl_t ctrlRaw;
	decodeCtrl_t ctrlD;
	regAddr_t ra1D;
	regAddr_t ra2D;
	word_t rd1D;
	word_t rd2D;
	word_t extImmD;

	// Stage registers
	deStage_t deStage;
	emStage_t emStage;
	mwStage_t mwStage;

	// Execute
	word_t fwdValA;
	word_t writeDataE;
	word_t srcA;
	word_t srcB;
	word_t aluResult;
	flags_t aluFlags;
	logic condEx;
	logic branchTaken;

	// Hazards and writeback
	logic stallF;
	logic stallD;
	logic flushD;
	logic flushE;
	fwdSel_t fwdA;
	fwdSel_t fwdB;
	word_t resultW;

	function automatic word_t fwdMux(input fwdSel_t sel, input word_t regVal,
			input word_t memVal, input word_t wbVal);
		case (sel)
			FROM_M: return memVal;
			FROM_W: return wbVal;
			default: return regVal;
		endcase
	endfunction

	// Taken branch redirects fetch one cycle after execute
	always_ff @(posedge clk) begin
		if (reset) begin
			pcF <= '0;
		end else if (branchTaken) begin
			pcF <= aluResult;
		end else if (!stallF) begin
			pcF <= pcF + 48'd4;
		end
	end

	always_ff @(posedge clk) begin
		if (reset || flushD) begin
			instrD <= '0;
			pcD <= '0;
			validD <= 1'b0;
		end else if (!stallD) begin
			instrD <= instr;
			pcD <= pcF;
			validD <= 1'b1;
		end
	end

	assign opD = opcode_t'(instrD[43:41]);

	decoder dec (
		.op(opD),
		.funct(instrD[40:35]),
		.ctrl(ctrlRaw)
	);

	// Flushed slot decodes to a bubble
	assign ctrlD = validD ? ctrlRaw : '0;

	// Stores read their data from Rd
	assign ra1D = instrD[34:30];
	assign ra2D = (opD == MEM) ? instrD[29:25] : instrD[4:0];

	regFile rf (
		.clk(clk),
		.we(mwStage.regWrite),
		.ra1(ra1D),
		.ra2(ra2D),
		.wa3(mwStage.wa3),
		.wd3(resultW),
		.rd1(rd1D),
		.rd2(rd2D)
	);

	// Branch offset counts words
	assign extImmD = (opD == BRANCH) ? {{22{instrD[23]}}, instrD[23:0], 2'b00}
		: {{24{instrD[23]}}, instrD[23:0]};

	always_ff @(posedge clk) begin
		if (reset || flushE) begin
			deStage <= '0;
		end else begin
			deStage.ctrl <= ctrlD;
			deStage.cond <= instrD[47:44];
			deStage.ra1 <= ra1D;
			deStage.ra2 <= ra2D;
			deStage.wa3 <= instrD[29:25];
			deStage.rd1 <= rd1D;
			deStage.rd2 <= rd2D;
			deStage.extImm <= extImmD;
			deStage.pc <= pcD;
		end
	end

	assign fwdValA = fwdMux(fwdA, deStage.rd1, emStage.aluOut, resultW);
	assign writeDataE = fwdMux(fwdB, deStage.rd2, emStage.aluOut, resultW);
	assign srcA = deStage.ctrl.branch ? deStage.pc + 48'd4 : fwdValA;
	assign srcB = deStage.ctrl.aluSrc ? deStage.extImm : writeDataE;

	alu aluUnit (
		.a(srcA),
		.b(srcB),
		.aluOp(deStage.ctrl.aluOp),
		.result(aluResult),
		.flags(aluFlags)
	);

	condLogic flagsUnit (
		.clk(clk),
		.reset(reset),
		.cond(deStage.cond),
		.aluFlags(aluFlags),
		.flagWrite(deStage.ctrl.flagWrite),
		.condEx(condEx)
	);

	assign branchTaken = deStage.ctrl.branch && condEx;

	always_ff @(posedge clk) begin
		if (reset) begin
			emStage <= '0;
		end else begin
			emStage.regWrite <= deStage.ctrl.regWrite && condEx;
			emStage.memWrite <= deStage.ctrl.memWrite && condEx;
			emStage.memToReg <= deStage.ctrl.memToReg;
			emStage.wa3 <= deStage.wa3;
			emStage.aluOut <= aluResult;
			emStage.writeData <= writeDataE;
		end
	end

	assign memWrite = emStage.memWrite;
	assign aluOut = emStage.aluOut;
	assign writeData = emStage.writeData;

	always_ff @(posedge clk) begin
		if (reset) begin
			mwStage <= '0;
		end else begin
			mwStage.regWrite <= emStage.regWrite;
			mwStage.memToReg <= emStage.memToReg;
			mwStage.wa3 <= emStage.wa3;
			mwStage.aluOut <= emStage.aluOut;
			mwStage.readData <= readData;
		end
	end

	assign resultW = mwStage.memToReg ? mwStage.readData : mwStage.aluOut;

	hazardUnit hazard (
		.deStage(deStage),
		.emStage(emStage),
		.mwStage(mwStage),
		.ra1D(ra1D),
		.ra2D(ra2D),
		.branchTaken(branchTaken),
		.stallF(stallF),
		.stallD(stallD),
		.flushD(flushD),
		.flushE(flushE),
		.fwdA(fwdA),
		.fwdB(fwdB)
	);

endmodule

`default_nettype wire

/* verilog/cpuPkg.sv */
`default_nettype none

package cpuPkg;

	typedef logic [47:0] word_t;
	typedef logic [4:0] regAddr_t;
	// N, Z, C, V from bit 3 down to bit 0
	typedef logic [3:0] flags_t;
	typedef logic [3:0] cond_t;

	typedef enum cond_t {
		EQ = 4'h0,
		NE = 4'h1,
		GE = 4'hA,
		LT = 4'hB,
		GT = 4'hC,
		LE = 4'hD,
		AL = 4'hE
	} condCode_t;

	// Encodings match the command field of data instructions
	typedef enum logic [3:0] {
		AND = 4'b0000,
		SUB = 4'b0010,
		ADD = 4'b0100,
		ORR = 4'b1100,
		MOV = 4'b1101
	} aluOp_t;

	typedef enum logic [2:0] {
		DATA = 3'd0,
		MEM = 3'd1,
		BRANCH = 3'd2
	} opcode_t;

	typedef enum logic [1:0] {
		REGFILE = 2'b00,
		FROM_W = 2'b01,
		FROM_M = 2'b10
	} fwdSel_t;

	typedef struct packed {
		logic regWrite;
		logic memWrite;
		logic memToReg;
		logic aluSrc;
		logic branch;
		logic flagWrite;
		aluOp_t aluOp;
	} decodeCtrl_t;

	// Decode to execute
	typedef struct packed {
		decodeCtrl_t ctrl;
		cond_t cond;
		regAddr_t ra1;
		regAddr_t ra2;
		regAddr_t wa3;
		word_t rd1;
		word_t rd2;
		word_t extImm;
		word_t pc;
	} deStage_t;

	// Execute to memory
	typedef struct packed {
		logic regWrite;
		logic memWrite;
		logic memToReg;
		regAddr_t wa3;
		word_t aluOut;
		word_t writeData;
	} emStage_t;

	// Memory to writeback
	typedef struct packed {
		logic regWrite;
		logic memToReg;
		regAddr_t wa3;
		word_t aluOut;
		word_t readData;
	} mwStage_t;

endpackage

`default_nettype wire

/* verilog/cpuTop.sv */
`default_nettype none

module cpuTop import cpuPkg::*; #(
	parameter int DataWords = 64
) (
	input logic clk,
	input logic reset,
	input word_t instr,
	output word_t pcF,
	output logic memWrite,
	output word_t aluOut,
	output word_t writeData
);

	word_t readData;

	cpu core (
		.clk(clk),
		.reset(reset),
		.instr(instr),
		.readData(readData),
		.pcF(pcF),
		.aluOut(aluOut),
		.writeData(writeData),
		.memWrite(memWrite)
	);

	dataMem #(
		.DataWords(DataWords)
	) dataRam (
		.clk(clk),
		.we(memWrite),
		.addr(aluOut),
		.wd(writeData),
		.rd(readData)
	);

endmodule

`default_nettype wire

/* verilog/dataMem.sv */
`default_nettype none

module dataMem import cpuPkg::*; #(
	parameter int DataWords = 64
) (
	input logic clk,
	input logic we,
	input word_t addr,
	input word_t wd,
	output word_t rd
);

	localparam int IdxW = $clog2(DataWords);

	word_t ram [DataWords];
	logic [IdxW-1:0] idx;

	// Byte address to word index wrapping at the depth
	assign idx = IdxW'((addr >> 2) % DataWords);

	always_ff @(posedge clk) begin
		if (we) begin
			ram[idx] <= wd;
		end
	end

	assign rd = ram[idx];

endmodule

`default_nettype wire

/* verilog/decoder.sv */
`default_nettype none

module decoder import cpuPkg::*; (
	input opcode_t op,
	input logic [5:0] funct,
	output decodeCtrl_t ctrl
);

	always_comb begin
		ctrl = '0;
		case (op)
			DATA: begin
				// Immediate select, command, set-flags bit
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = funct[5];
				ctrl.aluOp = aluOp_t'(funct[4:1]);
				ctrl.flagWrite = funct[0];
			end
			MEM: begin
				// Address is base plus immediate
				ctrl.aluSrc = 1'b1;
				ctrl.aluOp = ADD;
				// Load bit sits at instruction bit 36
				if (funct[1]) begin
					ctrl.regWrite = 1'b1;
					ctrl.memToReg = 1'b1;
				end else begin
					ctrl.memWrite = 1'b1;
				end
			end
			BRANCH: begin
				// Target is PC plus 4 plus the shifted immediate
				ctrl.branch = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.aluOp = ADD;
			end
			default: begin
				ctrl = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

/* verilog/hazardUnit.sv */
`default_nettype none

module hazardUnit import cpuPkg::*; (
	input deStage_t deStage,
	input emStage_t emStage,
	input mwStage_t mwStage,
	input regAddr_t ra1D,
	input regAddr_t ra2D,
	input logic branchTaken,
	output logic stallF,
	output logic stallD,
	output logic flushD,
	output logic flushE,
	output fwdSel_t fwdA,
	output fwdSel_t fwdB
);

	logic loadUse;

	// Memory stage wins over writeback
	function automatic fwdSel_t pickSource(input regAddr_t ra, input emStage_t em,
			input mwStage_t mw);
		if (em.regWrite && em.wa3 == ra) begin
			return FROM_M;
		end else if (mw.regWrite && mw.wa3 == ra) begin
			return FROM_W;
		end
		return REGFILE;
	endfunction

	assign fwdA = pickSource(deStage.ra1, emStage, mwStage);
	assign fwdB = pickSource(deStage.ra2, emStage, mwStage);

	// Load in execute feeding an instruction in decode
	assign loadUse = deStage.ctrl.memToReg &&
		(deStage.wa3 == ra1D || deStage.wa3 == ra2D);

	assign stallF = loadUse;
	assign stallD = loadUse;
	assign flushD = branchTaken;
	assign flushE = loadUse || branchTaken;

endmodule

`default_nettype wire

/* verilog/regFile.sv */
`default_nettype none

module regFile import cpuPkg::*; (
	input logic clk,
	input logic we,
	input regAddr_t ra1,
	input regAddr_t ra2,
	input regAddr_t wa3,
	input word_t wd3,
	output word_t rd1,
	output word_t rd2
);

	word_t regs [32];

	always_ff @(posedge clk) begin
		if (we) begin
			regs[wa3] <= wd3;
		end
	end

	// Write-through so decode sees the value written this cycle
	assign rd1 = (we && ra1 == wa3) ? wd3 : regs[ra1];
	assign rd2 = (we && ra2 == wa3) ? wd3 : regs[ra2];

endmodule

`default_nettype wire
